// ==== Bender.yml ====
package:
  name: banked_mem_ctrl

sources:
  - files:
      - verilog/mem_cfg_pkg.sv
      - verilog/mem_port_pkg.sv
      - verilog/port_credit_rx.sv
      - verilog/bank_xbar.sv
      - verilog/resp_router.sv
      - verilog/banked_mem_ctrl.sv
  - target: test
    files:
      - testbench/tb_bank_model.sv
      - testbench/tb_banked_mem_ctrl.sv

// ==== testbench/tb_bank_model.sv ====
/*
 * Behavioral four-bank SRAM
 * Grants from LFSR bits and returns read data after the fixed latency
 */
`timescale 1ns/1ns
`default_nettype none

module tb_bank_model
  import mem_cfg_pkg::*;
  import mem_port_pkg::*;
(
  input  wire logic                      clk_i,
  input  wire logic      [NumBanks-1:0]  mem_req_i,
  input  wire bank_req_t [NumBanks-1:0]  mem_bank_i,
  output logic           [NumBanks-1:0]  mem_gnt_o,
  output data_t          [NumBanks-1:0]  mem_rdata_o
);

  data_t                mem_q [NumBanks][2**BankAddrWidth];
  // Read data pipe, one stage per latency cycle
  data_t [NumBanks-1:0] pipe_q [MemLatency];
  logic  [31:0]         lfsr_q = 32'h06bbaf87;
  logic  [NumBanks-1:0] gnt_en = '0;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Start contents, built from bank and word index together
  function automatic data_t fill_word(input logic [9:0] idx);
    return {6'h2b, idx, 6'h15, idx ^ 10'h3a5};
  endfunction

  initial begin
    for (int b = 0; b < NumBanks; b++) begin
      for (int w = 0; w < 2**BankAddrWidth; w++) begin
        mem_q[b][w] = fill_word({bank_addr_t'(w), bank_sel_t'(b)});
      end
    end
  end

  // One LFSR bit per bank and cycle decides the grant
  always @(negedge clk_i) begin
    logic [31:0] s;
    s = lfsr_q;
    for (int b = 0; b < NumBanks; b++) begin
      s = lfsr_next(s);
      gnt_en[b] <= s[0];
    end
    lfsr_q <= s;
  end

  assign mem_gnt_o   = mem_req_i & gnt_en;
  assign mem_rdata_o = pipe_q[MemLatency-1];

  always @(posedge clk_i) begin
    for (int b = 0; b < NumBanks; b++) begin
      // Idle slots carry X so misrouted data stands out
      pipe_q[0][b] <= 'x;
      if (mem_gnt_o[b]) begin
        if (mem_bank_i[b].we) begin
          for (int k = 0; k < StrbWidth; k++) begin
            if (mem_bank_i[b].strb[k]) begin
              mem_q[b][mem_bank_i[b].addr][8*k +: 8] <= mem_bank_i[b].wdata[8*k +: 8];
            end
          end
        end else begin
          pipe_q[0][b] <= mem_q[b][mem_bank_i[b].addr];
        end
      end
    end
    for (int i = 1; i < MemLatency; i++) begin
      pipe_q[i] <= pipe_q[i-1];
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tb_banked_mem_ctrl.sv ====
/*
 * Testbench of the two-port banked SRAM controller
 * Applies a request table under credit flow control and checks bank
 * requests, response timing and read data against a reference memory
 */
`timescale 1ns/1ns
`default_nettype none

module tb_banked_mem_ctrl
  import mem_cfg_pkg::*;
  import mem_port_pkg::*;
();

  // One table row, exp holds the word a read must return
  typedef struct {
    string name;
    logic  is_rd;
    addr_t addr;
    data_t data;
    strb_t strb;
    data_t exp;
  } row_t;

  // Response still to come, due is the cycle it must show up
  typedef struct {
    int row;
    int due;
  } rsp_t;

  logic                     clk_i = 1'b0;
  logic                     rst_i;
  logic                     wr_valid_i;
  wr_req_t                  wr_req_i;
  logic                     wr_credit_o;
  logic                     rd_valid_i;
  rd_req_t                  rd_req_i;
  logic                     rd_credit_o;
  logic      [NumBanks-1:0] mem_req_o;
  bank_req_t [NumBanks-1:0] mem_bank_o;
  logic      [NumBanks-1:0] mem_gnt_i;
  data_t     [NumBanks-1:0] mem_rdata_i;
  logic                     rd_rsp_valid_o;
  data_t                    rd_rsp_data_o;
  logic                     wr_ack_o;

  row_t  rows [$];
  // Reference memory indexed by byte address bits 11:2
  data_t ref_mem [1024];
  int    word_busy [1024];
  int    busy_total = 0;
  int    wr_credits = CreditCount;
  int    rd_credits = CreditCount;
  logic  wr_used;
  logic  rd_used;
  // Issued but not yet granted, per port in issue order
  int    wr_pend [$];
  int    rd_pend [$];
  rsp_t  wr_rsp [$];
  rsp_t  rd_rsp [$];
  int    cyc = 0;
  int    checks = 0;
  int    value_errs = 0;
  int    other_errs = 0;

  banked_mem_ctrl dut (.*);

  tb_bank_model u_banks (
    .clk_i       (clk_i),
    .mem_req_i   (mem_req_o),
    .mem_bank_i  (mem_bank_o),
    .mem_gnt_o   (mem_gnt_i),
    .mem_rdata_o (mem_rdata_i)
  );

  always #2 clk_i = ~clk_i;

  task automatic check_data(input string name, input data_t exp, input data_t got);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("error %s: expected %h, got %h", name, exp, got);
    end
  endtask

  task automatic check_bank(input string name, input bank_req_t exp, input bank_req_t got);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("error %s: expected %h, got %h", name, exp, got);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("error %s: expected %b, got %b", name, exp, got);
    end
  endtask

  task automatic report_and_stop();
    $display("summary: %0d checks, %0d value errors, %0d other errors",
             checks, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  // Same start contents as the bank model, from the 10-bit word index
  function automatic data_t fill_word(input logic [9:0] idx);
    return {6'h2b, idx, 6'h15, idx ^ 10'h3a5};
  endfunction

  // Rows are added in issue order, the reference follows them
  task automatic add_row(input string name, input logic is_rd, input addr_t addr,
                         input data_t data, input strb_t strb);
    row_t row;
    row.name  = name;
    row.is_rd = is_rd;
    row.addr  = addr;
    row.data  = data;
    row.strb  = strb;
    row.exp   = ref_mem[addr[11:2]];
    if (!is_rd) begin
      for (int k = 0; k < 4; k++) begin
        if (strb[k]) begin
          ref_mem[addr[11:2]][8*k +: 8] = data[8*k +: 8];
        end
      end
    end
    rows.push_back(row);
  endtask

  task automatic build_table();
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = fill_word(i[9:0]);
    end
    add_row("wr_bank0_full",       1'b0, 16'h0000, 32'h1111_1111, 4'hf);
    add_row("wr_bank1_full",       1'b0, 16'h0014, 32'h2222_2222, 4'hf);
    add_row("wr_bank2_full",       1'b0, 16'h0028, 32'h3333_3333, 4'hf);
    add_row("wr_bank3_full",       1'b0, 16'h003c, 32'h4444_4444, 4'hf);
    add_row("rd_bank0",            1'b1, 16'h0000, '0, '0);
    add_row("rd_bank1",            1'b1, 16'h0014, '0, '0);
    add_row("rd_bank2",            1'b1, 16'h0028, '0, '0);
    add_row("rd_bank3",            1'b1, 16'h003c, '0, '0);
    add_row("rd_bank2_untouched",  1'b1, 16'h0238, '0, '0);
    add_row("wr_bank2_low_half",   1'b0, 16'h0128, 32'ha5a5_a5a5, 4'h3);
    // Read waits for the ack, then goes out with the next write to bank 2
    add_row("rd_bank2_low_half",   1'b1, 16'h0128, '0, '0);
    add_row("wr_bank2_same_cycle", 1'b0, 16'h0238, 32'h0bad_cafe, 4'hf);
    add_row("rd_bank2_after_pair", 1'b1, 16'h0238, '0, '0);
    // Upper address bits lie outside the bank geometry
    add_row("wr_bank1_high_addr",  1'b0, 16'hf0a4, 32'h5a5a_5a5a, 4'ha);
    add_row("rd_bank1_merged",     1'b1, 16'h00a4, '0, '0);
    add_row("wr_bank1_same_cycle", 1'b0, 16'h00b4, 32'h1234_5678, 4'hf);
    add_row("wr_bank3_no_strobe",  1'b0, 16'h0fcc, 32'hffff_ffff, 4'h0);
    add_row("rd_bank3_unchanged",  1'b1, 16'h0fcc, '0, '0);
    add_row("wr_bank0_top_byte0",  1'b0, 16'h0ff0, 32'hdead_beef, 4'h1);
    add_row("wr_bank0_top_byte3",  1'b0, 16'h0ff0, 32'hcafe_f00d, 4'h8);
    add_row("rd_bank0_top",        1'b1, 16'h0ff0, '0, '0);
    add_row("rd_bank1_second_word", 1'b1, 16'h00b4, '0, '0);
  endtask

  function automatic logic can_issue(input int r);
    // Hold back any request to a word still in flight
    if (word_busy[rows[r].addr[11:2]] != 0) begin
      return 1'b0;
    end
    if (rows[r].is_rd) begin
      return !rd_used && rd_credits > 0;
    end
    return !wr_used && wr_credits > 0;
  endfunction

  task automatic issue_row(input int r);
    if (rows[r].is_rd) begin
      rd_valid_i <= 1'b1;
      rd_req_i   <= '{addr: rows[r].addr};
      rd_pend.push_back(r);
      rd_credits--;
      rd_used = 1'b1;
    end else begin
      wr_valid_i <= 1'b1;
      wr_req_i   <= '{addr: rows[r].addr, data: rows[r].data, strb: rows[r].strb};
      wr_pend.push_back(r);
      wr_credits--;
      wr_used = 1'b1;
    end
    word_busy[rows[r].addr[11:2]]++;
    busy_total++;
  endtask

  task automatic retire(input int r);
    word_busy[rows[r].addr[11:2]]--;
    busy_total--;
  endtask

  // Credit pulse seen, the oldest request of that port was granted
  task automatic note_grant(input logic is_rd, input logic [NumBanks-1:0] gnt);
    int        r;
    bank_req_t exp;
    if ((is_rd ? rd_pend.size() : wr_pend.size()) == 0) begin
      other_errs++;
      $display("credit returned on the %s port with no request pending",
               is_rd ? "read" : "write");
      return;
    end
    if (is_rd) begin
      r = rd_pend.pop_front();
      rd_credits++;
    end else begin
      r = wr_pend.pop_front();
      wr_credits++;
    end
    // Bank from byte address bits 3:2, word from bits 11:4
    exp.addr  = rows[r].addr[11:4];
    exp.we    = !is_rd;
    exp.wdata = is_rd ? '0 : rows[r].data;
    exp.strb  = is_rd ? '0 : rows[r].strb;
    check_bit(rows[r].name, 1'b1, gnt[rows[r].addr[3:2]]);
    check_bank(rows[r].name, exp, mem_bank_o[rows[r].addr[3:2]]);
    if (is_rd) begin
      rd_rsp.push_back('{row: r, due: cyc + MemLatency});
    end else begin
      wr_rsp.push_back('{row: r, due: cyc + MemLatency});
    end
  endtask

  initial begin
    int idx;
    rst_i      = 1'b1;
    wr_valid_i = 1'b0;
    wr_req_i   = '0;
    rd_valid_i = 1'b0;
    rd_req_i   = '0;
    wr_used    = 1'b0;
    rd_used    = 1'b0;
    build_table();
    repeat (5) @(negedge clk_i);
    rst_i <= 1'b0;
    // Nothing issued yet, so every output stays low
    repeat (5) begin
      @(negedge clk_i);
      check_bit("quiet_after_reset", 1'b0,
                |{mem_req_o, wr_credit_o, rd_credit_o, rd_rsp_valid_o, wr_ack_o});
    end
    idx = 0;
    while (idx < rows.size()) begin
      @(negedge clk_i);
      wr_valid_i <= 1'b0;
      rd_valid_i <= 1'b0;
      wr_used = 1'b0;
      rd_used = 1'b0;
      // Up to one row per port per cycle, strictly in table order
      repeat (2) begin
        if (idx < rows.size() && can_issue(idx)) begin
          issue_row(idx);
          idx++;
        end
      end
    end
    @(negedge clk_i);
    wr_valid_i <= 1'b0;
    rd_valid_i <= 1'b0;
    wait (busy_total == 0);
    repeat (3) @(negedge clk_i);
    // All traffic drained, no bank request may linger
    check_bit("idle_after_drain", 1'b0, |mem_req_o);
    report_and_stop();
  end

  // Samples the values the DUT and the banks see at the rising edge
  always @(posedge clk_i) begin
    logic [NumBanks-1:0] wr_gnt;
    logic [NumBanks-1:0] rd_gnt;
    for (int b = 0; b < NumBanks; b++) begin
      wr_gnt[b] = mem_req_o[b] & mem_gnt_i[b] & mem_bank_o[b].we;
      rd_gnt[b] = mem_req_o[b] & mem_gnt_i[b] & ~mem_bank_o[b].we;
    end
    if (!rst_i) begin
      // Responses land exactly MemLatency cycles after grant
      if (wr_rsp.size() != 0 && wr_rsp[0].due == cyc) begin
        check_bit(rows[wr_rsp[0].row].name, 1'b1, wr_ack_o);
        retire(wr_rsp[0].row);
        wr_rsp.delete(0);
      end else begin
        check_bit("wr_ack_idle", 1'b0, wr_ack_o);
      end
      if (rd_rsp.size() != 0 && rd_rsp[0].due == cyc) begin
        check_bit(rows[rd_rsp[0].row].name, 1'b1, rd_rsp_valid_o);
        check_data(rows[rd_rsp[0].row].name, rows[rd_rsp[0].row].exp, rd_rsp_data_o);
        retire(rd_rsp[0].row);
        rd_rsp.delete(0);
      end else begin
        check_bit("rd_rsp_idle", 1'b0, rd_rsp_valid_o);
      end
      // Credit pulse coincides with the grant of that port
      check_bit("wr_credit_at_grant", |wr_gnt, wr_credit_o);
      check_bit("rd_credit_at_grant", |rd_gnt, rd_credit_o);
      if (wr_credit_o) begin
        note_grant(1'b0, wr_gnt);
      end
      if (rd_credit_o) begin
        note_grant(1'b1, rd_gnt);
      end
    end
    cyc++;
  end

  // Limit of 40 cycles per table row
  initial begin
    @(posedge clk_i);
    while (cyc < 40 * rows.size()) begin
      @(posedge clk_i);
    end
    other_errs++;
    $display("timeout after %0d cycles with %0d requests outstanding", cyc, busy_total);
    report_and_stop();
  end

endmodule

`default_nettype wire

// ==== verilog/bank_xbar.sv ====
/*
 * Two-port bank crossbar
 * Decodes bank and word address from each port head, arbitrates
 * round-robin per bank with lock-in until grant, drives the bank
 * requests and reports every grant for response routing
 */
`timescale 1ns/1ns
`default_nettype none

module bank_xbar
  import mem_cfg_pkg::*;
  import mem_port_pkg::*;
(
  input  wire logic                     clk_i,
  input  wire logic                     rst_i,
  // Head entries of the two credit buffers
  input  wire logic                     wr_head_valid_i,
  input  wire wr_req_t                  wr_head_i,
  input  wire logic                     rd_head_valid_i,
  input  wire rd_req_t                  rd_head_i,
  output logic                          wr_pop_o,
  output logic                          rd_pop_o,
  // Bank side request and grant
  output logic      [NumBanks-1:0]      mem_req_o,
  output bank_req_t [NumBanks-1:0]      mem_bank_o,
  input  wire logic [NumBanks-1:0]      mem_gnt_i,
  // Grant records for the response router
  output route_t                        wr_route_o,
  output route_t                        rd_route_o
);

  bank_sel_t  wr_sel;
  bank_sel_t  rd_sel;
  bank_addr_t wr_word;
  bank_addr_t rd_word;
  bank_req_t  wr_bank_req;
  bank_req_t  rd_bank_req;

  // Per bank, bit set means the read port
  logic [NumBanks-1:0] wr_hit;
  logic [NumBanks-1:0] rd_hit;
  logic [NumBanks-1:0] rd_win;
  logic [NumBanks-1:0] gnt;

  // Round-robin priority, set when the read port goes first next
  logic [NumBanks-1:0] prio_rd_q;
  // Lock-in of a waiting request and its port
  logic [NumBanks-1:0] lock_q;
  logic [NumBanks-1:0] lock_rd_q;

  // Byte address bits 3:2 pick the bank, 11:4 the word
  assign wr_sel  = wr_head_i.addr[BankSelOffset +: BankSelWidth];
  assign rd_sel  = rd_head_i.addr[BankSelOffset +: BankSelWidth];
  assign wr_word = wr_head_i.addr[BankSelOffset + BankSelWidth +: BankAddrWidth];
  assign rd_word = rd_head_i.addr[BankSelOffset + BankSelWidth +: BankAddrWidth];

  // Bank payload of each port
  assign wr_bank_req = '{
    addr:  wr_word,
    we:    1'b1,
    wdata: wr_head_i.data,
    strb:  wr_head_i.strb
  };
  assign rd_bank_req = '{
    addr:  rd_word,
    we:    1'b0,
    wdata: '0,
    strb:  '0
  };

  always_comb begin
    for (int b = 0; b < NumBanks; b++) begin
      wr_hit[b] = wr_head_valid_i && (wr_sel == bank_sel_t'(b));
      rd_hit[b] = rd_head_valid_i && (rd_sel == bank_sel_t'(b));
      // Locked port keeps the bank, its head cannot change before pop
      if (lock_q[b]) begin
        rd_win[b] = lock_rd_q[b];
      end else if (wr_hit[b] && rd_hit[b]) begin
        rd_win[b] = prio_rd_q[b];
      end else begin
        rd_win[b] = rd_hit[b];
      end
      mem_req_o[b]  = wr_hit[b] | rd_hit[b];
      mem_bank_o[b] = rd_win[b] ? rd_bank_req : wr_bank_req;
      gnt[b]        = mem_req_o[b] & mem_gnt_i[b];
    end
  end

  // A head targets one bank, so at most one grant per port
  assign wr_pop_o = |(gnt & ~rd_win);
  assign rd_pop_o = |(gnt & rd_win);

  assign wr_route_o = '{valid: wr_pop_o, sel: wr_sel};
  assign rd_route_o = '{valid: rd_pop_o, sel: rd_sel};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio_rd_q <= '0;
      lock_q    <= '0;
      lock_rd_q <= '0;
    end else begin
      for (int b = 0; b < NumBanks; b++) begin
        if (gnt[b]) begin
          // Other port goes first next time
          lock_q[b]    <= 1'b0;
          prio_rd_q[b] <= ~rd_win[b];
        end else if (mem_req_o[b]) begin
          // Stalled by the bank, hold the choice
          lock_q[b]    <= 1'b1;
          lock_rd_q[b] <= rd_win[b];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/banked_mem_ctrl.sv ====
/*
 * Two-port banked SRAM controller
 * Credit buffers on the write and read ports, a bank crossbar and a
 * response router returning data and acknowledges in grant order
 */
`timescale 1ns/1ns
`default_nettype none

module banked_mem_ctrl
  import mem_cfg_pkg::*;
  import mem_port_pkg::*;
(
  input  wire logic                     clk_i,
  input  wire logic                     rst_i,
  // Write request port
  input  wire logic                     wr_valid_i,
  input  wire wr_req_t                  wr_req_i,
  output logic                          wr_credit_o,
  // Read request port
  input  wire logic                     rd_valid_i,
  input  wire rd_req_t                  rd_req_i,
  output logic                          rd_credit_o,
  // Banks
  output logic      [NumBanks-1:0]      mem_req_o,
  output bank_req_t [NumBanks-1:0]      mem_bank_o,
  input  wire logic [NumBanks-1:0]      mem_gnt_i,
  input  wire data_t [NumBanks-1:0]     mem_rdata_i,
  // Responses
  output logic                          rd_rsp_valid_o,
  output data_t                         rd_rsp_data_o,
  output logic                          wr_ack_o
);

  // Buffer heads towards the crossbar
  logic    wr_head_valid;
  wr_req_t wr_head;
  logic    wr_pop;
  logic    rd_head_valid;
  rd_req_t rd_head;
  logic    rd_pop;

  // Grant records towards the router
  route_t  wr_route;
  route_t  rd_route;

  port_credit_rx #(
    .payload_t (wr_req_t)
  ) u_wr_rx (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .push_i       (wr_valid_i),
    .push_data_i  (wr_req_i),
    .head_valid_o (wr_head_valid),
    .head_data_o  (wr_head),
    .pop_i        (wr_pop),
    .credit_o     (wr_credit_o)
  );

  port_credit_rx #(
    .payload_t (rd_req_t)
  ) u_rd_rx (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .push_i       (rd_valid_i),
    .push_data_i  (rd_req_i),
    .head_valid_o (rd_head_valid),
    .head_data_o  (rd_head),
    .pop_i        (rd_pop),
    .credit_o     (rd_credit_o)
  );

  bank_xbar u_xbar (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .wr_head_valid_i (wr_head_valid),
    .wr_head_i       (wr_head),
    .rd_head_valid_i (rd_head_valid),
    .rd_head_i       (rd_head),
    .wr_pop_o        (wr_pop),
    .rd_pop_o        (rd_pop),
    .mem_req_o       (mem_req_o),
    .mem_bank_o      (mem_bank_o),
    .mem_gnt_i       (mem_gnt_i),
    .wr_route_o      (wr_route),
    .rd_route_o      (rd_route)
  );

  resp_router u_router (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .wr_route_i     (wr_route),
    .rd_route_i     (rd_route),
    .mem_rdata_i    (mem_rdata_i),
    .rd_rsp_valid_o (rd_rsp_valid_o),
    .rd_rsp_data_o  (rd_rsp_data_o),
    .wr_ack_o       (wr_ack_o)
  );

endmodule

`default_nettype wire

// ==== verilog/mem_cfg_pkg.sv ====
/*
 * Banked memory controller configuration
 * Geometry of the banks, fixed read latency and credit depth of the
 * request ports, plus the word types derived from them
 */
`default_nettype none

package mem_cfg_pkg;

  // Word geometry
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned AddrWidth = 16;

  // Bank geometry
  localparam int unsigned NumBanks      = 4;
  localparam int unsigned BankSelWidth  = $clog2(NumBanks);
  // Bank index sits just above the byte offset inside a word
  localparam int unsigned BankSelOffset = $clog2(StrbWidth);
  localparam int unsigned BankAddrWidth = 8;

  // Cycles from bank grant to read data
  localparam int unsigned MemLatency = 1;

  // Buffer depth per port, equal to the credits held by the sender
  localparam int unsigned CreditCount    = 2;
  localparam int unsigned CreditPtrWidth = (CreditCount > 1) ? $clog2(CreditCount) : 1;
  localparam int unsigned CreditCntWidth = $clog2(CreditCount + 1);

  // Port side byte address
  typedef logic [AddrWidth-1:0]     addr_t;
  // One memory word and its byte enables
  typedef logic [DataWidth-1:0]     data_t;
  typedef logic [StrbWidth-1:0]     strb_t;
  // Word address inside one bank
  typedef logic [BankAddrWidth-1:0] bank_addr_t;
  // Bank index
  typedef logic [BankSelWidth-1:0]  bank_sel_t;

  // Credit buffer bookkeeping
  typedef logic [CreditPtrWidth-1:0] credit_ptr_t;
  typedef logic [CreditCntWidth-1:0] credit_cnt_t;

endpackage

`default_nettype wire

// ==== verilog/mem_port_pkg.sv ====
/*
 * Banked memory controller payloads
 * Request structs of the write and read ports, the request sent to one
 * bank and one stage of the response routing shift register
 */
`default_nettype none

package mem_port_pkg;

  import mem_cfg_pkg::*;

  // One write request from the write port
  typedef struct packed {
    addr_t addr;
    data_t data;
    // Byte enables, active high
    strb_t strb;
  } wr_req_t;

  // One read request from the read port
  typedef struct packed {
    addr_t addr;
  } rd_req_t;

  // Request as it is driven onto one bank
  typedef struct packed {
    // Word address inside the bank
    bank_addr_t addr;
    // High for writes
    logic       we;
    data_t      wdata;
    strb_t      strb;
  } bank_req_t;

  // Response routing record, captured at grant
  typedef struct packed {
    logic      valid;
    // Bank that took the request
    bank_sel_t sel;
  } route_t;

endpackage

`default_nettype wire

// ==== verilog/port_credit_rx.sv ====
/*
 * Credit-counted request buffer for one port
 * Small FIFO whose free slots match the credits held by the sender,
 * every pop hands one credit back
 */
`timescale 1ns/1ns
`default_nettype none

module port_credit_rx
  import mem_cfg_pkg::*;
#(
  parameter type payload_t = logic
) (
  input  wire logic     clk_i,
  input  wire logic     rst_i,
  // Sender side, one entry per push
  input  wire logic     push_i,
  input  wire payload_t push_data_i,
  // Oldest entry towards the crossbar
  output logic          head_valid_o,
  output payload_t      head_data_o,
  input  wire logic     pop_i,
  // One pulse per entry leaving the buffer
  output logic          credit_o
);

  // Entry storage
  payload_t    mem_q [CreditCount];
  credit_ptr_t wr_ptr_q;
  credit_ptr_t rd_ptr_q;
  credit_cnt_t count_q;
  logic        do_pop;

  // Pointer increment with wrap at the buffer depth
  function automatic credit_ptr_t ptr_inc(input credit_ptr_t ptr);
    if (ptr == credit_ptr_t'(CreditCount - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign head_valid_o = (count_q != '0);
  assign head_data_o  = mem_q[rd_ptr_q];

  // Only pop an entry that is really there
  assign do_pop   = pop_i & head_valid_o;
  assign credit_o = do_pop;

  // Payload write, sender never pushes without a credit
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Level moves only when exactly one side is active
      if (push_i && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (!push_i && do_pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/resp_router.sv ====
/*
 * Response router
 * Delays the grant records of both ports by the memory read latency,
 * picks read data from the recorded bank and raises write acknowledges
 */
`timescale 1ns/1ns
`default_nettype none

module resp_router
  import mem_cfg_pkg::*;
  import mem_port_pkg::*;
(
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  // Grant records, valid in the grant cycle
  input  wire route_t                wr_route_i,
  input  wire route_t                rd_route_i,
  // Read data of every bank
  input  wire data_t [NumBanks-1:0]  mem_rdata_i,
  // Read response pulse with data
  output logic                       rd_rsp_valid_o,
  output data_t                      rd_rsp_data_o,
  // Write acknowledge pulse
  output logic                       wr_ack_o
);

  // Latency pipes, stage 0 loads at the grant edge
  route_t wr_sr_q [MemLatency];
  route_t rd_sr_q [MemLatency];
  route_t wr_tail;
  route_t rd_tail;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < MemLatency; i++) begin
        wr_sr_q[i] <= '0;
        rd_sr_q[i] <= '0;
      end
    end else begin
      wr_sr_q[0] <= wr_route_i;
      rd_sr_q[0] <= rd_route_i;
      // Shift towards the tail
      for (int i = 1; i < MemLatency; i++) begin
        wr_sr_q[i] <= wr_sr_q[i-1];
        rd_sr_q[i] <= rd_sr_q[i-1];
      end
    end
  end

  // Tail lines up with the bank read data
  assign wr_tail = wr_sr_q[MemLatency-1];
  assign rd_tail = rd_sr_q[MemLatency-1];

  // Read data comes from the bank named in the record
  assign rd_rsp_valid_o = rd_tail.valid;
  assign rd_rsp_data_o  = mem_rdata_i[rd_tail.sel];

  // Writes return no data, only the pulse
  assign wr_ack_o = wr_tail.valid;

endmodule

`default_nettype wire

// ==== vlog.f ====
verilog/mem_cfg_pkg.sv
verilog/mem_port_pkg.sv
verilog/port_credit_rx.sv
verilog/bank_xbar.sv
verilog/resp_router.sv
verilog/banked_mem_ctrl.sv
testbench/tb_bank_model.sv
testbench/tb_banked_mem_ctrl.sv
